/* Makefile */
SRCS := $(shell cat compile.f)

.PHONY: run clean

run: obj_6/Vdcache_tb obj_4/Vdcache_tb
	./obj_6/Vdcache_tb | tee /dev/stderr | grep -q "TEST PASS"
	./obj_4/Vdcache_tb | tee /dev/stderr | grep -q "TEST PASS"

# one build per index width, the directory suffix is the width
obj_%/Vdcache_tb: compile.f $(SRCS)
	verilator --binary --timing --assert -GINDEX_W=$* --top-module dcache_tb --Mdir obj_$* -f compile.f

clean:
	rm -rf obj_6 obj_4

/* compile.f */
design/dcache_pkg.sv
design/line_sram.sv
design/tag_store.sv
design/dcache_ctrl.sv
design/dcache_top.sv
dv/mem_model.sv
dv/dcache_tb.sv

/* design/dcache_ctrl.sv */
// data cache controller: tag lookup, refill, victim write-back, hit read/write and flush walk
`timescale 1ns/100ps

module dcache_ctrl #(
    parameter int INDEX_W = 6,
    localparam int TAG_W = $bits(dcache_pkg::addr_t) - INDEX_W - dcache_pkg::OFFSET_W
) (
    input  logic                   clk,
    input  logic                   rst,
    // core side
    input  logic                   req_valid_i,
    input  logic                   req_write_i,
    input  dcache_pkg::addr_t      req_addr_i,
    input  dcache_pkg::word_t      req_wdata_i,
    input  dcache_pkg::wmask_t     req_wmask_i,
    input  logic                   flush_i,
    output logic                   resp_ready_o,
    output dcache_pkg::word_t      resp_rdata_o,
    output logic                   flush_done_o,
    output logic                   idle_o,
    // memory side
    output logic                   mem_valid_o,
    output logic                   mem_write_o,
    output dcache_pkg::addr_t      mem_addr_o,
    output dcache_pkg::line_t      mem_wdata_o,
    input  dcache_pkg::line_t      mem_rdata_i,
    input  logic                   mem_ready_i,
    // tag store
    output logic [INDEX_W-1:0]     tag_index_o,
    input  logic                   tag_valid_i,
    input  logic                   tag_dirty_i,
    input  logic [TAG_W-1:0]       tag_tag_i,
    output logic                   tag_upd_o,
    output logic [INDEX_W-1:0]     tag_upd_index_o,
    output logic [TAG_W-1:0]       tag_upd_tag_o,
    output logic                   tag_set_valid_o,
    output logic                   tag_set_dirty_o,
    output logic                   tag_clear_dirty_o,
    // line store
    output logic [INDEX_W-1:0]     ram_addr_o,
    output dcache_pkg::line_mask_t ram_wmask_o,
    output dcache_pkg::line_t      ram_wdata_o,
    input  dcache_pkg::line_t      ram_rdata_i
);

    localparam int OFFSET_W = dcache_pkg::OFFSET_W;
    localparam int WORD_W   = $bits(dcache_pkg::word_t);

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;

    dcache_pkg::ctrl_state_t state_q;
    dcache_pkg::ctrl_state_t state_d;

    // request held for the whole transaction
    dcache_pkg::addr_t  req_addr_q;
    logic               req_write_q;
    dcache_pkg::word_t  req_wdata_q;
    dcache_pkg::wmask_t req_wmask_q;

    index_t flush_idx_q;
    index_t req_index;
    index_t cur_index;
    tag_t   req_tag;

    logic in_flush;
    logic hit;
    logic line_dirty;
    logic flush_line_done;
    logic flush_last;
    logic refill_done;
    logic flush_wb_done;
    logic issue;
    logic upper_half;

    assign req_index  = req_addr_q[OFFSET_W +: INDEX_W];
    assign req_tag    = req_addr_q[OFFSET_W + INDEX_W +: TAG_W];
    assign upper_half = req_addr_q[OFFSET_W-1]; // which word of the line

    assign in_flush  = (state_q == dcache_pkg::FLUSH_CHECK) ||
                       (state_q == dcache_pkg::FLUSH_WRITE);
    assign cur_index = in_flush ? flush_idx_q : req_index;

    assign hit        = tag_valid_i && (tag_tag_i == req_tag);
    assign line_dirty = tag_valid_i && tag_dirty_i;

    assign flush_line_done = !line_dirty || mem_ready_i;
    assign flush_last      = &flush_idx_q;

    assign refill_done   = (state_q == dcache_pkg::REFILL) && mem_ready_i;
    assign flush_wb_done = (state_q == dcache_pkg::FLUSH_WRITE) && line_dirty && mem_ready_i;

    // start a memory transfer once per visit; valid stays up until ready
    assign issue = !mem_valid_o &&
                   ((state_q == dcache_pkg::WRITEBACK) ||
                    (state_q == dcache_pkg::REFILL) ||
                    ((state_q == dcache_pkg::FLUSH_WRITE) && line_dirty));

    assign idle_o = (state_q == dcache_pkg::IDLE);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            dcache_pkg::IDLE: begin
                if (flush_i) begin
                    state_d = dcache_pkg::FLUSH_CHECK; // flush wins over a request
                end else if (req_valid_i) begin
                    state_d = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (hit) begin
                    state_d = dcache_pkg::HIT_READ;
                end else if (line_dirty) begin
                    state_d = dcache_pkg::WRITEBACK;
                end else begin
                    state_d = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::WRITEBACK: begin
                if (mem_ready_i) begin
                    state_d = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: begin
                if (mem_ready_i) begin
                    state_d = dcache_pkg::LOOKUP; // retry, now a hit
                end
            end
            dcache_pkg::HIT_READ: begin
                state_d = req_write_q ? dcache_pkg::HIT_WRITE : dcache_pkg::IDLE;
            end
            dcache_pkg::HIT_WRITE: begin
                state_d = dcache_pkg::IDLE;
            end
            dcache_pkg::FLUSH_CHECK: begin
                state_d = dcache_pkg::FLUSH_WRITE; // line data arrives here
            end
            dcache_pkg::FLUSH_WRITE: begin
                if (flush_line_done) begin
                    state_d = flush_last ? dcache_pkg::IDLE : dcache_pkg::FLUSH_CHECK;
                end
            end
            default: state_d = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= dcache_pkg::IDLE;
            resp_ready_o <= 1'b0;
            flush_done_o <= 1'b0;
            flush_idx_q  <= '0;
        end else begin
            state_q <= state_d;
            // reads and writes both answer from HIT_READ
            resp_ready_o <= (state_q == dcache_pkg::HIT_READ);
            flush_done_o <= (state_q == dcache_pkg::FLUSH_WRITE) && flush_line_done && flush_last;
            if (state_q == dcache_pkg::IDLE) begin
                flush_idx_q <= '0;
            end else if ((state_q == dcache_pkg::FLUSH_WRITE) && flush_line_done) begin
                flush_idx_q <= flush_idx_q + index_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::IDLE) begin
            req_addr_q  <= req_addr_i;
            req_write_q <= req_write_i;
            req_wdata_q <= req_wdata_i;
            req_wmask_q <= req_wmask_i;
        end
        if (state_q == dcache_pkg::HIT_READ) begin
            resp_rdata_o <= upper_half ? ram_rdata_i[WORD_W +: WORD_W]
                                       : ram_rdata_i[0 +: WORD_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid_o <= 1'b0;
        end else if (issue) begin
            mem_valid_o <= 1'b1;
        end else if (mem_ready_i) begin
            mem_valid_o <= 1'b0; // drops the cycle after ready
        end
    end

    // transfer fields frozen at issue
    always_ff @(posedge clk) begin
        if (issue) begin
            mem_write_o <= (state_q != dcache_pkg::REFILL);
            mem_wdata_o <= ram_rdata_i; // victim line, unused on refill
            if (state_q == dcache_pkg::REFILL) begin
                mem_addr_o <= {req_addr_q[$bits(dcache_pkg::addr_t)-1:OFFSET_W],
                               {OFFSET_W{1'b0}}};
            end else begin
                mem_addr_o <= {tag_tag_i, cur_index, {OFFSET_W{1'b0}}};
            end
        end
    end

    assign tag_index_o       = cur_index;
    assign tag_upd_index_o   = cur_index;
    assign tag_upd_tag_o     = req_tag;
    assign tag_upd_o         = refill_done || flush_wb_done ||
                               (state_q == dcache_pkg::HIT_WRITE);
    assign tag_set_valid_o   = refill_done;
    assign tag_set_dirty_o   = (state_q == dcache_pkg::HIT_WRITE);
    assign tag_clear_dirty_o = refill_done || flush_wb_done;

    assign ram_addr_o = cur_index;

    always_comb begin
        ram_wmask_o = '0;
        ram_wdata_o = mem_rdata_i;
        if (refill_done) begin
            ram_wmask_o = '1; // whole burst
        end else if (state_q == dcache_pkg::HIT_WRITE) begin
            ram_wdata_o = {req_wdata_q, req_wdata_q};
            ram_wmask_o = upper_half ? {req_wmask_q, dcache_pkg::wmask_t'(0)}
                                     : {dcache_pkg::wmask_t'(0), req_wmask_q};
        end
    end

    // memory request fields must not move while the memory is still working on them
    mem_hold_a: assert property (@(posedge clk) disable iff (rst)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o) &&
                                        $stable(mem_write_o));

    resp_pulse_a: assert property (@(posedge clk) disable iff (rst)
        resp_ready_o |=> !resp_ready_o);

endmodule

/* design/dcache_pkg.sv */
// shared widths, data types and controller states for the data cache; referenced by scoped name
package dcache_pkg;

    // byte offset bits inside a 16-byte line
    localparam int OFFSET_W = 4;

    // core byte address
    typedef logic [31:0] addr_t;

    // core load/store word
    typedef logic [63:0] word_t;

    // one enable per byte of a word
    typedef logic [7:0] wmask_t;

    // one cache line, also one memory burst
    typedef logic [127:0] line_t;

    // one enable per byte of a line
    typedef logic [15:0] line_mask_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        WRITEBACK,
        HIT_READ,
        HIT_WRITE,
        FLUSH_CHECK,
        FLUSH_WRITE
    } ctrl_state_t;

endpackage

/* design/dcache_top.sv */
// direct-mapped write-back data cache top; connects controller, tag store and line store
`timescale 1ns/100ps

module dcache_top #(
    parameter int INDEX_W = 6
) (
    input  logic               clk,
    input  logic               rst,
    // core side
    input  logic               req_valid_i,
    input  logic               req_write_i,
    input  dcache_pkg::addr_t  req_addr_i,
    input  dcache_pkg::word_t  req_wdata_i,
    input  dcache_pkg::wmask_t req_wmask_i,
    input  logic               flush_i,
    output logic               resp_ready_o,
    output dcache_pkg::word_t  resp_rdata_o,
    output logic               flush_done_o,
    output logic               idle_o,
    // memory side
    output logic               mem_valid_o,
    output logic               mem_write_o,
    output dcache_pkg::addr_t  mem_addr_o,
    output dcache_pkg::line_t  mem_wdata_o,
    input  dcache_pkg::line_t  mem_rdata_i,
    input  logic               mem_ready_i
);

    localparam int TAG_W = $bits(dcache_pkg::addr_t) - INDEX_W - dcache_pkg::OFFSET_W;

    // tag store link
    logic [INDEX_W-1:0] tag_index;
    logic               tag_valid;
    logic               tag_dirty;
    logic [TAG_W-1:0]   tag_tag;
    logic               tag_upd;
    logic [INDEX_W-1:0] tag_upd_index;
    logic [TAG_W-1:0]   tag_upd_tag;
    logic               tag_set_valid;
    logic               tag_set_dirty;
    logic               tag_clear_dirty;

    // line store link
    logic [INDEX_W-1:0]     ram_addr;
    dcache_pkg::line_mask_t ram_wmask;
    dcache_pkg::line_t      ram_wdata;
    dcache_pkg::line_t      ram_rdata;

    dcache_ctrl #(
        .INDEX_W(INDEX_W)
    ) u_ctrl (
        .clk               (clk),
        .rst               (rst),
        .req_valid_i       (req_valid_i),
        .req_write_i       (req_write_i),
        .req_addr_i        (req_addr_i),
        .req_wdata_i       (req_wdata_i),
        .req_wmask_i       (req_wmask_i),
        .flush_i           (flush_i),
        .resp_ready_o      (resp_ready_o),
        .resp_rdata_o      (resp_rdata_o),
        .flush_done_o      (flush_done_o),
        .idle_o            (idle_o),
        .mem_valid_o       (mem_valid_o),
        .mem_write_o       (mem_write_o),
        .mem_addr_o        (mem_addr_o),
        .mem_wdata_o       (mem_wdata_o),
        .mem_rdata_i       (mem_rdata_i),
        .mem_ready_i       (mem_ready_i),
        .tag_index_o       (tag_index),
        .tag_valid_i       (tag_valid),
        .tag_dirty_i       (tag_dirty),
        .tag_tag_i         (tag_tag),
        .tag_upd_o         (tag_upd),
        .tag_upd_index_o   (tag_upd_index),
        .tag_upd_tag_o     (tag_upd_tag),
        .tag_set_valid_o   (tag_set_valid),
        .tag_set_dirty_o   (tag_set_dirty),
        .tag_clear_dirty_o (tag_clear_dirty),
        .ram_addr_o        (ram_addr),
        .ram_wmask_o       (ram_wmask),
        .ram_wdata_o       (ram_wdata),
        .ram_rdata_i       (ram_rdata)
    );

    tag_store #(
        .INDEX_W(INDEX_W)
    ) u_tags (
        .clk           (clk),
        .rst           (rst),
        .look_index_i  (tag_index),
        .look_valid_o  (tag_valid),
        .look_dirty_o  (tag_dirty),
        .look_tag_o    (tag_tag),
        .upd_i         (tag_upd),
        .upd_index_i   (tag_upd_index),
        .upd_tag_i     (tag_upd_tag),
        .set_valid_i   (tag_set_valid),
        .set_dirty_i   (tag_set_dirty),
        .clear_dirty_i (tag_clear_dirty)
    );

    line_sram #(
        .INDEX_W(INDEX_W)
    ) u_lines (
        .clk     (clk),
        .addr_i  (ram_addr),
        .wmask_i (ram_wmask),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

/* design/line_sram.sv */
// single-port line store of the data cache; registered read every cycle, byte-masked write
`timescale 1ns/100ps

module line_sram #(
    parameter int INDEX_W = 6
) (
    input  logic                   clk,
    input  logic [INDEX_W-1:0]     addr_i,
    input  dcache_pkg::line_mask_t wmask_i,
    input  dcache_pkg::line_t      wdata_i,
    output dcache_pkg::line_t      rdata_o
);

    localparam int LINES = 2 ** INDEX_W;
    localparam int BYTES = $bits(dcache_pkg::line_mask_t);

    dcache_pkg::line_t mem_q [LINES];

    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTES; b++) begin
            if (wmask_i[b]) begin
                mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
        rdata_o <= mem_q[addr_i]; // old contents on a same-cycle write
    end

    // a write to an unknown address would corrupt an arbitrary line
    wr_addr_known_a: assert property (@(posedge clk)
        (|wmask_i) |-> !$isunknown(addr_i));

endmodule

/* design/tag_store.sv */
// valid, dirty and tag state per cache line; combinational lookup port, clocked update port
`timescale 1ns/100ps

module tag_store #(
    parameter int INDEX_W = 6,
    localparam int TAG_W = $bits(dcache_pkg::addr_t) - INDEX_W - dcache_pkg::OFFSET_W
) (
    input  logic               clk,
    input  logic               rst,
    // lookup
    input  logic [INDEX_W-1:0] look_index_i,
    output logic               look_valid_o,
    output logic               look_dirty_o,
    output logic [TAG_W-1:0]   look_tag_o,
    // update
    input  logic               upd_i,
    input  logic [INDEX_W-1:0] upd_index_i,
    input  logic [TAG_W-1:0]   upd_tag_i,
    input  logic               set_valid_i,
    input  logic               set_dirty_i,
    input  logic               clear_dirty_i
);

    localparam int LINES = 2 ** INDEX_W;

    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;
    logic [TAG_W-1:0] tag_q [LINES];

    assign look_valid_o = valid_q[look_index_i];
    assign look_dirty_o = dirty_q[look_index_i];
    assign look_tag_o   = tag_q[look_index_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (upd_i) begin
            if (set_valid_i) begin
                valid_q[upd_index_i] <= 1'b1; // refill
            end
            if (set_dirty_i) begin
                dirty_q[upd_index_i] <= 1'b1; // write hit
            end else if (clear_dirty_i) begin
                dirty_q[upd_index_i] <= 1'b0; // refill or flush write-back
            end
        end
    end

    // tag only changes when a new line is brought in
    always_ff @(posedge clk) begin
        if (upd_i && set_valid_i) begin
            tag_q[upd_index_i] <= upd_tag_i;
        end
    end

    // a line is either being made dirty or cleaned, never both at once
    dirty_excl_a: assert property (@(posedge clk) disable iff (rst)
        upd_i |-> !(set_dirty_i && clear_dirty_i));

endmodule

/* dv/dcache_tb.sv */
// testbench for the data cache; random loads and stores against a flat byte image, then flushes
`timescale 1ns/100ps

module dcache_tb;

    parameter int INDEX_W = 6;

    localparam int LINES   = 2 ** INDEX_W;
    localparam int BYTES   = 4096; // same as the memory model image
    localparam int TIMEOUT = 200;
    localparam int RUNS    = 400;

    logic               clk = 1'b0;
    logic               rst;
    logic               req_valid;
    logic               req_write;
    dcache_pkg::addr_t  req_addr;
    dcache_pkg::word_t  req_wdata;
    dcache_pkg::wmask_t req_wmask;
    logic               flush;
    logic               resp_ready;
    dcache_pkg::word_t  resp_rdata;
    logic               flush_done;
    logic               idle;
    logic               mem_valid;
    logic               mem_write;
    dcache_pkg::addr_t  mem_addr;
    dcache_pkg::line_t  mem_wdata;
    dcache_pkg::line_t  mem_rdata;
    logic               mem_ready;

    integer seed;
    int     errors;
    int     timeouts;

    // reference memory as the core sees it, plus which line each index holds
    logic [7:0] ref_mem [BYTES];
    logic       ref_valid [LINES];
    logic       ref_dirty [LINES];
    logic [7:0] ref_line [LINES];

    always #4 clk = ~clk;

    dcache_top #(
        .INDEX_W(INDEX_W)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid),
        .req_write_i  (req_write),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .req_wmask_i  (req_wmask),
        .flush_i      (flush),
        .resp_ready_o (resp_ready),
        .resp_rdata_o (resp_rdata),
        .flush_done_o (flush_done),
        .idle_o       (idle),
        .mem_valid_o  (mem_valid),
        .mem_write_o  (mem_write),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_rdata_i  (mem_rdata),
        .mem_ready_i  (mem_ready)
    );

    mem_model u_mem (
        .clk         (clk),
        .rst         (rst),
        .mem_valid_i (mem_valid),
        .mem_write_i (mem_write),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_rdata_o (mem_rdata),
        .mem_ready_o (mem_ready)
    );

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // one load or store, with the expected line traffic predicted first
    task automatic access(input logic wr, input dcache_pkg::addr_t addr,
                          input dcache_pkg::word_t wdata, input dcache_pkg::wmask_t wmask);
        logic [7:0]        line;
        logic [7:0]        victim;
        logic [11:0]       base;
        logic              evict;
        int                idx;
        int                exp_rd;
        int                exp_wr;
        int                cnt;
        dcache_pkg::word_t exp_data;
        if (timeouts != 0) begin
            return;
        end
        line   = addr[11:4];
        idx    = int'(line) % LINES;
        base   = {addr[11:3], 3'b000};
        victim = ref_line[idx];
        evict  = 1'b0;
        exp_rd = u_mem.rd_count;
        exp_wr = u_mem.wr_count;
        if (!ref_valid[idx] || ref_line[idx] != line) begin
            evict = ref_valid[idx] && ref_dirty[idx];
            if (evict) begin
                exp_wr++;
            end
            exp_rd++;
            ref_valid[idx] = 1'b1;
            ref_line[idx]  = line;
            ref_dirty[idx] = 1'b0;
        end
        for (int b = 0; b < 8; b++) begin
            if (wr && wmask[b]) begin
                ref_mem[base + 12'(b)] = wdata[b*8 +: 8];
            end
            exp_data[b*8 +: 8] = ref_mem[base + 12'(b)];
        end
        if (wr) begin
            ref_dirty[idx] = 1'b1;
        end

        @(negedge clk);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = wdata;
        req_wmask = wmask;
        cnt = 0;
        while (!resp_ready && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        req_valid = 1'b0;
        if (!resp_ready) begin
            timeouts++;
            $display("timeout: no response to the %s at %h", wr ? "write" : "read", addr);
            return;
        end

        if (!wr) begin
            check("read data", resp_rdata, exp_data);
        end
        check("memory reads", 64'(u_mem.rd_count), 64'(exp_rd));
        check("memory writes", 64'(u_mem.wr_count), 64'(exp_wr));
        if (evict) begin
            check("write-back address", 64'(u_mem.last_wr_addr), 64'({victim, 4'h0}));
            for (int b = 0; b < 16; b++) begin
                check("write-back byte", 64'(u_mem.store[{victim, 4'(b)}]),
                      64'(ref_mem[{victim, 4'(b)}]));
            end
        end
    endtask

    task automatic flush_all();
        int exp_wr;
        int cnt;
        if (timeouts != 0) begin
            return;
        end
        exp_wr = u_mem.wr_count;
        for (int i = 0; i < LINES; i++) begin
            if (ref_valid[i] && ref_dirty[i]) begin
                exp_wr++;
            end
            ref_dirty[i] = 1'b0;
        end
        @(negedge clk);
        flush = 1'b1;
        cnt = 0;
        while (!flush_done && cnt < TIMEOUT * LINES) begin // budget per line of the walk
            @(negedge clk);
            cnt++;
        end
        flush = 1'b0;
        if (!flush_done) begin
            timeouts++;
            $display("timeout: flush did not complete");
            return;
        end
        check("flush write-backs", 64'(u_mem.wr_count), 64'(exp_wr));
        for (int a = 0; a < BYTES; a++) begin
            check("memory after flush", 64'(u_mem.store[a]), 64'(ref_mem[a]));
        end
    endtask

    initial begin
        dcache_pkg::addr_t addr;
        seed      = 32;
        errors    = 0;
        timeouts  = 0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wmask = '0;
        flush     = 1'b0;
        for (int i = 0; i < LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_dirty[i] = 1'b0;
            ref_line[i]  = '0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int a = 0; a < BYTES; a++) begin
            ref_mem[a] = u_mem.store[a]; // start-up image
        end

        // quiet after reset
        repeat (4) begin
            @(negedge clk);
            check("idle after reset", 64'(idle), 64'd1);
            check("mem valid after reset", 64'(mem_valid), 64'd0);
            check("resp ready after reset", 64'(resp_ready), 64'd0);
            check("flush done after reset", 64'(flush_done), 64'd0);
        end

        // cold miss, then hits in the same line
        access(1'b0, 32'h0000_0100, '0, '0);
        access(1'b0, 32'h0000_0100, '0, '0);
        access(1'b0, 32'h0000_0108, '0, '0);

        // dirty line evicted by a conflicting read
        access(1'b1, 32'h0000_0040, 64'h0123_4567_89ab_cdef, 8'h5c);
        access(1'b0, dcache_pkg::addr_t'(32'h40 + LINES * 16), '0, '0);

        for (int n = 0; n < RUNS; n++) begin
            addr = dcache_pkg::addr_t'($random(seed)) & 32'h0000_0ff8;
            if ($random(seed) & 1) begin
                access(1'b1, addr, {$random(seed), $random(seed)}, 8'($random(seed)));
                access(1'b0, addr, '0, '0);
            end else begin
                access(1'b0, addr, '0, '0);
            end
        end

        flush_all();
        flush_all(); // nothing left dirty
        check("bad memory transfers", 64'(u_mem.bad_count), 64'd0);

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* dv/mem_model.sv */
// behavioral burst memory for the cache testbench; 4 KB image, 1 to 4 cycle random latency
`timescale 1ns/100ps

module mem_model (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_valid_i,
    input  logic              mem_write_i,
    input  dcache_pkg::addr_t mem_addr_i,
    input  dcache_pkg::line_t mem_wdata_i,
    output dcache_pkg::line_t mem_rdata_o,
    output logic              mem_ready_o
);

    localparam int BYTES = 4096;

    logic [7:0] store [BYTES];
    int rd_count = 0;
    int wr_count = 0;
    int bad_count = 0; // outside the image or not line aligned
    dcache_pkg::addr_t last_wr_addr = '0;

    integer seed = 32;
    int wait_cnt = 0;
    logic busy = 1'b0;
    logic ready_q = 1'b0;
    dcache_pkg::line_t rdata_q = '0;
    dcache_pkg::line_t rd_line;

    assign mem_ready_o = ready_q;
    assign mem_rdata_o = rdata_q;

    // start-up contents, a function of every address bit
    initial begin
        for (int a = 0; a < BYTES; a++) begin
            store[a] = 8'(a * 37 + (a >> 8) * 11) ^ 8'h5a;
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            ready_q <= 1'b0;
            busy = 1'b0;
        end else if (ready_q) begin
            ready_q <= 1'b0; // valid already dropped on the edge that saw ready
            busy = 1'b0;
        end else if (busy) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
                if (mem_addr_i >= 32'(BYTES) || mem_addr_i[3:0] != 4'd0) begin
                    bad_count++;
                end
                for (int b = 0; b < 16; b++) begin
                    if (mem_write_i) begin
                        store[{mem_addr_i[11:4], 4'(b)}] = mem_wdata_i[b*8 +: 8];
                    end
                    rd_line[b*8 +: 8] = store[{mem_addr_i[11:4], 4'(b)}];
                end
                if (mem_write_i) begin
                    wr_count++;
                    last_wr_addr = mem_addr_i;
                end else begin
                    rd_count++;
                    rdata_q <= rd_line;
                end
                ready_q <= 1'b1;
            end
        end else if (mem_valid_i) begin
            busy = 1'b1;
            wait_cnt = 1 + ($random(seed) & 3);
        end
    end

endmodule
